//--- build.f
hw/lane_pkg.sv
hw/chan_pkg.sv
hw/lane_if.sv
hw/xbar.sv
hw/var_fifo.sv
hw/lane_steer.sv
hw/lane_merge.sv
hw/lane_pack_top.sv
testbench/tb_lane_pack.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lane_pack -f build.f -o tb_lane_pack

out=$(./obj_dir/tb_lane_pack)
echo "$out"

if echo "$out" | grep -q "^test passed$"; then
    exit 0
fi
exit 1

//--- testbench/tb_lane_pack.sv
`timescale 1ns/1ps

module tb_lane_pack;

    import lane_pkg::*;
    import chan_pkg::*;

    localparam int EW          = LANE_ELEM_WIDTH;
    localparam int NE          = LANE_NUM_ELEM;
    localparam int DEPTH       = LANE_FIFO_DEPTH;
    localparam int NCH         = CH_NUM_DEFAULT;
    localparam int CHW         = CH_ID_WIDTH_DEFAULT;
    localparam int LW          = $clog2(NE+1);
    localparam int SW          = $clog2(NE);
    localparam int CLK_PERIOD  = 100;
    localparam int RST_CYCLES  = 5;
    localparam int BEAT_ALLOW  = 30;  // cycles granted per table beat
    localparam int DRAIN_QUIET = 16;  // silent output cycles before a drain wait gives up
    localparam int N_ROWS      = 10;
    localparam int C_CH        = 0;
    localparam int C_INL       = 1;
    localparam int C_IST       = 2;
    localparam int C_BEATS     = 3;
    localparam int C_ONL       = 4;
    localparam int C_OST       = 5;
    localparam int C_STALL     = 6;
    localparam int C_WAIT      = 7;

    ////////////////////////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////////////////////////

    // channel, in lanes, in start, beats, out lanes, out start,
    // cycles with out_ready low, wait for the drain (1) or move on at once (0)
    int tbl [N_ROWS][8] = '{
        '{0, 3, 0, 4, 2, 1,  0, 1},  // three lanes in, two lanes out
        '{1, 3, 1, 2, 2, 0,  0, 1},
        '{2, 3, 2, 3, 2, 0,  0, 1},  // start plus count runs past the beat
        '{2, 1, 3, 4, 3, 1,  0, 1},
        '{3, 4, 0, 8, 4, 0, 30, 1},  // long stall fills the FIFO and the steer
        '{0, 4, 0, 3, 2, 0, 99, 0},
        '{1, 4, 0, 3, 2, 0, 99, 0},
        '{2, 2, 1, 4, 2, 0, 99, 0},
        '{3, 3, 0, 2, 2, 0,  6, 1},  // the release lets all four channels compete
        '{0, 1, 0, 2, 1, 0,  0, 1}   // single lanes out empty every channel
    };

    logic                  clk_i = 1'b0;
    logic                  arst_n;
    logic [CHW-1:0]        in_chan;
    logic [LW-1:0]         in_num_lanes;
    logic [SW-1:0]         in_start_lane;
    logic [NE-1:0][EW-1:0] in_data;
    logic                  in_valid;
    logic                  in_ready;
    logic                  in_req_valid;
    logic [LW-1:0]         out_num_lanes;
    logic [SW-1:0]         out_start_lane;
    logic [NE-1:0][EW-1:0] out_data;
    logic [CHW-1:0]        out_chan;
    logic [LW-1:0]         out_count;
    logic                  out_valid;
    logic                  out_ready;
    logic                  out_req_valid;

    logic [EW-1:0]         sb [NCH][$];  // accepted elements per channel with the oldest first
    logic [31:0]           lcg_state = 32'd81;
    int                    drv_errors = 0;
    int                    mon_errors = 0;
    logic                  prev_valid;
    logic                  prev_fire;
    logic                  prev_stall;
    logic                  have_last;
    logic [CHW-1:0]        last_chan;
    logic [NE-1:0][EW-1:0] stall_data;
    logic [CHW-1:0]        stall_chan;
    logic [LW-1:0]         stall_count;

    lane_pack_top UUT (.*);

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    function automatic logic [EW-1:0] next_elem();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return EW'(lcg_state >> 16);  // the low bits of the state cycle too fast
    endfunction

    // true when no further output beat can form at the current window
    function automatic bit drained();
        bit idle;
        idle = !out_valid;
        for (int c = 0; c < NCH; c++) begin
            if (sb[c].size() >= int'(out_num_lanes)) begin
                idle = 1'b0;
            end
        end
        return idle;
    endfunction

    ////////////////////////////////////////////////////////////
    // driver
    ////////////////////////////////////////////////////////////

    task automatic run_row(input int r);
        int sent;
        int cyc;
        int quiet;
        bit bad;
        bit fire;
        sent  = 0;
        cyc   = 0;
        quiet = 0;
        bad   = (tbl[r][C_IST] + tbl[r][C_INL]) > NE;
        out_num_lanes  = LW'(tbl[r][C_ONL]);
        out_start_lane = SW'(tbl[r][C_OST]);
        in_chan        = CHW'(tbl[r][C_CH]);
        in_num_lanes   = LW'(tbl[r][C_INL]);
        in_start_lane  = SW'(tbl[r][C_IST]);
        while (sent < tbl[r][C_BEATS]
               || (tbl[r][C_WAIT] != 0 && !drained() && quiet < DRAIN_QUIET)) begin
            out_ready = (cyc >= tbl[r][C_STALL]);
            if (sent < tbl[r][C_BEATS]) begin
                if (!in_valid) begin
                    for (int i = 0; i < NE; i++) begin
                        in_data[i] = next_elem();  // lanes outside the window get noise too
                    end
                    in_valid = 1'b1;
                end
            end else begin
                in_valid = 1'b0;
            end
            @(negedge clk_i);
            fire = in_valid && in_ready;
            if (out_valid || sent < tbl[r][C_BEATS]) begin
                quiet = 0;
            end else begin
                quiet++;
            end
            if (bad && in_valid) begin
                assert (!in_req_valid && !in_ready) else begin
                    drv_errors++;
                    $display("[FAIL] %0t: row %0d overruns the beat but was offered", $time, r);
                end
            end
            @(posedge clk_i);
            #1;
            if (fire || (bad && in_valid)) begin
                sent++;
                in_valid = 1'b0;
            end
            cyc++;
        end
        in_valid = 1'b0;
    endtask

    initial begin : driver
        arst_n         = 1'b0;
        in_chan        = '0;
        in_num_lanes   = LW'(1);
        in_start_lane  = '0;
        in_data        = '0;
        in_valid       = 1'b0;
        out_num_lanes  = LW'(1);
        out_start_lane = '0;
        out_ready      = 1'b0;
        repeat (RST_CYCLES) begin
            @(negedge clk_i);
            assert (!out_valid) else begin
                drv_errors++;
                $display("[FAIL] %0t: out_valid high during reset", $time);
            end
        end
        @(posedge clk_i);
        #1;
        arst_n = 1'b1;
        @(negedge clk_i);
        assert (in_ready && in_req_valid && out_req_valid && !out_valid) else begin
            drv_errors++;
            $display("[FAIL] %0t: handshake flags wrong right after reset", $time);
        end
        @(posedge clk_i);
        #1;
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end
        for (int c = 0; c < NCH; c++) begin
            assert (sb[c].size() == 0) else begin
                drv_errors++;
                $display("[FAIL] %0t: channel %0d kept %0d elements", $time, c, sb[c].size());
            end
        end
        $display("%0d driver errors, %0d monitor errors", drv_errors, mon_errors);
        if (drv_errors + mon_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // monitor and scoreboard
    ////////////////////////////////////////////////////////////

    always @(negedge clk_i) begin : monitor
        logic [EW-1:0] expect_elem;
        int            held;
        bit            new_beat;
        if (!arst_n) begin
            prev_valid = 1'b0;
            prev_fire  = 1'b0;
            prev_stall = 1'b0;
            have_last  = 1'b0;
        end else begin
            // count only the FIFO and the steer register and leave the output register out
            for (int c = 0; c < NCH; c++) begin
                held = (out_valid && int'(out_chan) == c) ? int'(out_count) : 0;
                assert (sb[c].size() - held <= DEPTH + NE) else begin
                    mon_errors++;
                    $display("[FAIL] %0t: channel %0d took %0d elements", $time, c,
                             sb[c].size() - held);
                end
            end
            if (prev_stall) begin
                assert (out_valid && out_data == stall_data && out_chan == stall_chan
                        && out_count == stall_count) else begin
                    mon_errors++;
                    $display("[FAIL] %0t: output beat changed while stalled", $time);
                end
            end
            new_beat = out_valid && (!prev_valid || prev_fire);
            // a repeat is fair only if every other channel was short at the load edge
            if (new_beat && have_last && out_chan == last_chan) begin
                for (int d = 0; d < NCH; d++) begin
                    assert (d == int'(out_chan) || sb[d].size() < int'(out_count) + 2*NE)
                    else begin
                        mon_errors++;
                        $display("[FAIL] %0t: channel %0d served twice while %0d waited",
                                 $time, out_chan, d);
                    end
                end
            end
            if (new_beat) begin
                last_chan = out_chan;
                have_last = 1'b1;
            end
            if (out_valid && out_ready) begin
                assert (out_count == out_num_lanes) else begin
                    mon_errors++;
                    $display("[FAIL] %0t: out_count %0d, expected %0d", $time, out_count,
                             out_num_lanes);
                end
                for (int i = 0; i < NE; i++) begin
                    if (i >= int'(out_start_lane)
                        && i < int'(out_start_lane) + int'(out_count)) begin
                        assert (sb[out_chan].size() != 0) else begin
                            mon_errors++;
                            $display("[FAIL] %0t: channel %0d delivered an element never sent",
                                     $time, out_chan);
                        end
                        if (sb[out_chan].size() != 0) begin
                            expect_elem = sb[out_chan].pop_front();
                            assert (out_data[i] == expect_elem) else begin
                                mon_errors++;
                                $display("[FAIL] %0t: channel %0d lane %0d got %h, expected %h",
                                         $time, out_chan, i, out_data[i], expect_elem);
                            end
                        end
                    end else begin
                        assert (out_data[i] == '0) else begin
                            mon_errors++;
                            $display("[FAIL] %0t: lane %0d outside the window is %h", $time,
                                     i, out_data[i]);
                        end
                    end
                end
            end
            if (in_valid && in_ready) begin
                for (int i = 0; i < int'(in_num_lanes); i++) begin
                    sb[in_chan].push_back(in_data[int'(in_start_lane) + i]);
                end
            end
            prev_valid  = out_valid;
            prev_fire   = out_valid && out_ready;
            prev_stall  = out_valid && !out_ready;
            stall_data  = out_data;
            stall_chan  = out_chan;
            stall_count = out_count;
        end
    end

    ////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////

    initial begin : watchdog
        int total_beats;
        total_beats = 0;
        for (int r = 0; r < N_ROWS; r++) begin
            total_beats += tbl[r][C_BEATS];
        end
        #((RST_CYCLES + total_beats * BEAT_ALLOW) * CLK_PERIOD);
        $display("watchdog expired before the %0d table beats were drained", total_beats);
        $display("test failed");
        $finish;
    end

endmodule

//--- hw/lane_pack_top.sv
`timescale 1ns/1ps

module lane_pack_top #(
    parameter int ELEM_WIDTH = lane_pkg::LANE_ELEM_WIDTH,
    parameter int NUM_ELEM   = lane_pkg::LANE_NUM_ELEM,
    parameter int FIFO_DEPTH = lane_pkg::LANE_FIFO_DEPTH,
    parameter int NUM_CH     = chan_pkg::CH_NUM_DEFAULT
) (
    input  logic                                clk_i,
    input  logic                                arst_n,
    input  logic [$clog2(NUM_CH)-1:0]           in_chan,
    input  logic [$clog2(NUM_ELEM+1)-1:0]       in_num_lanes,
    input  logic [$clog2(NUM_ELEM)-1:0]         in_start_lane,
    input  logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0] in_data,
    input  logic                                in_valid,
    output logic                                in_ready,
    output logic                                in_req_valid,
    input  logic [$clog2(NUM_ELEM+1)-1:0]       out_num_lanes,
    input  logic [$clog2(NUM_ELEM)-1:0]         out_start_lane,
    output logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0] out_data,
    output logic [$clog2(NUM_CH)-1:0]           out_chan,
    output logic [$clog2(NUM_ELEM+1)-1:0]       out_count,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic                                out_req_valid
);

    lane_if #(.ELEM_WIDTH(ELEM_WIDTH), .NUM_ELEM(NUM_ELEM)) wr_if [NUM_CH] ();  // steer to FIFO
    lane_if #(.ELEM_WIDTH(ELEM_WIDTH), .NUM_ELEM(NUM_ELEM)) rd_if [NUM_CH] ();  // FIFO to merge

    logic [$clog2(FIFO_DEPTH+1)-1:0] elem_available [NUM_CH];

    lane_steer #(
        .ELEM_WIDTH    ( ELEM_WIDTH    ),
        .NUM_ELEM      ( NUM_ELEM      ),
        .NUM_CH        ( NUM_CH        )
    ) u_steer (
        .clk_i         ( clk_i         ),
        .arst_n        ( arst_n        ),
        .in_chan       ( in_chan       ),
        .in_num_lanes  ( in_num_lanes  ),
        .in_start_lane ( in_start_lane ),
        .in_data       ( in_data       ),
        .in_valid      ( in_valid      ),
        .in_ready      ( in_ready      ),
        .in_req_valid  ( in_req_valid  ),
        .ch            ( wr_if         )
    );

    generate
        for (genvar g = 0; g < NUM_CH; g++) begin : g_ch
            var_fifo #(
                .ELEM_WIDTH     ( ELEM_WIDTH        ),
                .NUM_ELEM       ( NUM_ELEM          ),
                .FIFO_DEPTH     ( FIFO_DEPTH        )
            ) u_fifo (
                .clk_i          ( clk_i             ),
                .arst_n         ( arst_n            ),
                .wr             ( wr_if[g]          ),
                .rd             ( rd_if[g]          ),
                .elem_available ( elem_available[g] )
            );
        end
    endgenerate

    lane_merge #(
        .ELEM_WIDTH     ( ELEM_WIDTH     ),
        .NUM_ELEM       ( NUM_ELEM       ),
        .FIFO_DEPTH     ( FIFO_DEPTH     ),
        .NUM_CH         ( NUM_CH         )
    ) u_merge (
        .clk_i          ( clk_i          ),
        .arst_n         ( arst_n         ),
        .ch             ( rd_if          ),
        .elem_available ( elem_available ),
        .out_num_lanes  ( out_num_lanes  ),
        .out_start_lane ( out_start_lane ),
        .out_data       ( out_data       ),
        .out_chan       ( out_chan       ),
        .out_count      ( out_count      ),
        .out_valid      ( out_valid      ),
        .out_ready      ( out_ready      ),
        .out_req_valid  ( out_req_valid  )
    );

endmodule

//--- hw/lane_merge.sv
`timescale 1ns/1ps

module lane_merge #(
    parameter int ELEM_WIDTH = lane_pkg::LANE_ELEM_WIDTH,
    parameter int NUM_ELEM   = lane_pkg::LANE_NUM_ELEM,
    parameter int FIFO_DEPTH = lane_pkg::LANE_FIFO_DEPTH,
    parameter int NUM_CH     = chan_pkg::CH_NUM_DEFAULT
) (
    input  logic                                clk_i,
    input  logic                                arst_n,
    lane_if.dst_pull                            ch [NUM_CH],
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]     elem_available [NUM_CH],
    input  logic [$clog2(NUM_ELEM+1)-1:0]       out_num_lanes,
    input  logic [$clog2(NUM_ELEM)-1:0]         out_start_lane,
    output logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0] out_data,
    output logic [$clog2(NUM_CH)-1:0]           out_chan,
    output logic [$clog2(NUM_ELEM+1)-1:0]       out_count,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic                                out_req_valid
);

    localparam int CH_W  = $clog2(NUM_CH);
    localparam int CNT_W = $clog2(FIFO_DEPTH+1);

    logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0] ch_data [NUM_CH];
    logic [NUM_CH-1:0]                   ch_valid;
    logic [NUM_CH-1:0]                   eligible;
    logic [CH_W-1:0]                     last_grant;
    logic [CH_W-1:0]                     grant;
    logic                                found;
    logic                                pop;

    assign out_req_valid = (int'(out_start_lane) + int'(out_num_lanes)) <= NUM_ELEM;

    // every FIFO sees the same window, only the granted one gets ready
    generate
        for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
            assign ch[i].num_lanes  = out_num_lanes;
            assign ch[i].start_lane = out_start_lane;
            assign ch[i].ready      = pop && (grant == CH_W'(i));
            assign ch_data[i]       = ch[i].data;
            assign ch_valid[i]      = ch[i].valid;
            assign eligible[i]      = out_req_valid && (elem_available[i] >= CNT_W'(out_num_lanes));
        end
    endgenerate

    ////////////////////////////////////////////////////////////
    // round-robin pick, search starts one past the last grant
    ////////////////////////////////////////////////////////////

    always_comb begin : rr_pick
        logic [CH_W-1:0] idx;
        found = 1'b0;
        grant = last_grant;
        for (int k = 1; k <= NUM_CH; k++) begin
            idx = last_grant + CH_W'(k);  // wraps since NUM_CH is a power of two
            if (!found && eligible[idx]) begin
                found = 1'b1;
                grant = idx;
            end
        end
    end

    assign pop = found && (!out_valid || out_ready);

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            out_valid  <= 1'b0;
            last_grant <= CH_W'(NUM_CH - 1);  // channel 0 is served first
        end else if (pop) begin
            out_valid  <= 1'b1;
            last_grant <= grant;
        end else if (out_ready) begin
            out_valid  <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop) begin
            out_data  <= ch_data[grant];
            out_chan  <= grant;
            out_count <= out_num_lanes;
        end
    end

    a_out_hold: assert property (@(posedge clk_i) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_chan)
                                    && $stable(out_count));

    // the count seen here and the FIFO's own valid must tell the same story
    a_pop_valid: assert property (@(posedge clk_i) disable iff (!arst_n)
        pop |-> ch_valid[grant]);

endmodule

//--- hw/lane_steer.sv
`timescale 1ns/1ps

module lane_steer #(
    parameter int ELEM_WIDTH = lane_pkg::LANE_ELEM_WIDTH,
    parameter int NUM_ELEM   = lane_pkg::LANE_NUM_ELEM,
    parameter int NUM_CH     = chan_pkg::CH_NUM_DEFAULT
) (
    input  logic                                clk_i,
    input  logic                                arst_n,
    input  logic [$clog2(NUM_CH)-1:0]           in_chan,
    input  logic [$clog2(NUM_ELEM+1)-1:0]       in_num_lanes,
    input  logic [$clog2(NUM_ELEM)-1:0]         in_start_lane,
    input  logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0] in_data,
    input  logic                                in_valid,
    output logic                                in_ready,
    output logic                                in_req_valid,
    lane_if.src                                 ch [NUM_CH]
);

    localparam int CH_W = $clog2(NUM_CH);

    logic                                hold_valid;
    logic [CH_W-1:0]                     hold_chan;
    logic [$clog2(NUM_ELEM+1)-1:0]       hold_lanes;
    logic [$clog2(NUM_ELEM)-1:0]         hold_start;
    logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0] hold_data;
    logic [NUM_CH-1:0]                   ch_ready;
    logic [NUM_CH-1:0]                   ch_req_valid;
    logic                                drain;
    logic                                accept;

    // the beat is shown to every FIFO but only the addressed one sees valid
    generate
        for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
            assign ch[i].valid      = hold_valid && (hold_chan == CH_W'(i));
            assign ch[i].num_lanes  = hold_lanes;
            assign ch[i].start_lane = hold_start;
            assign ch[i].data       = hold_data;
            assign ch_ready[i]      = ch[i].ready;
            assign ch_req_valid[i]  = ch[i].req_valid;
        end
    endgenerate

    assign drain        = hold_valid && ch_ready[hold_chan];
    assign in_req_valid = (int'(in_start_lane) + int'(in_num_lanes)) <= NUM_ELEM;
    assign in_ready     = in_req_valid && (!hold_valid || drain);  // refill in the drain cycle
    assign accept       = in_valid && in_ready;

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            hold_valid <= 1'b0;
        end else if (accept) begin
            hold_valid <= 1'b1;
        end else if (drain) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            hold_chan  <= in_chan;
            hold_lanes <= in_num_lanes;
            hold_start <= in_start_lane;
            hold_data  <= in_data;
        end
    end

    a_hold_kept: assert property (@(posedge clk_i) disable iff (!arst_n)
        hold_valid && !drain |=> hold_valid && $stable(hold_chan) && $stable(hold_lanes)
                                 && $stable(hold_start) && $stable(hold_data));

    // the FIFO repeats the range check, both sides must agree on a held beat
    a_req_agree: assert property (@(posedge clk_i) disable iff (!arst_n)
        hold_valid |-> ch_req_valid[hold_chan]);

endmodule

//--- hw/var_fifo.sv
`timescale 1ns/1ps

module var_fifo #(
    parameter int ELEM_WIDTH = lane_pkg::LANE_ELEM_WIDTH,
    parameter int NUM_ELEM   = lane_pkg::LANE_NUM_ELEM,
    parameter int FIFO_DEPTH = lane_pkg::LANE_FIFO_DEPTH
) (
    input  logic                            clk_i,
    input  logic                            arst_n,
    lane_if.dst                             wr,
    lane_if.src_pull                        rd,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] elem_available
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH+1);
    localparam int SEL_W = $clog2(NUM_ELEM);

    logic [ELEM_WIDTH-1:0] mem [FIFO_DEPTH];  // circular element store
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      space_available;
    logic                  wr_fire;
    logic                  rd_fire;

    logic [NUM_ELEM-1:0][SEL_W-1:0]      wr_sel;
    logic [NUM_ELEM-1:0][SEL_W-1:0]      rd_sel;
    logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0] wr_x;    // accepted lanes packed down to lane 0
    logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0] rd_raw;  // the oldest elements with the oldest in lane 0
    logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0] rd_x;

    // pointer step with wrap at FIFO_DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] wrap_add(input logic [PTR_W-1:0] base, input int step);
        int sum;
        sum = int'(base) + step;
        if (sum >= FIFO_DEPTH) begin
            sum = sum - FIFO_DEPTH;
        end
        return PTR_W'(sum);
    endfunction

    ////////////////////////////////////////////////////////////
    // handshake
    ////////////////////////////////////////////////////////////

    assign wr.req_valid = (int'(wr.start_lane) + int'(wr.num_lanes)) <= NUM_ELEM;
    assign rd.req_valid = (int'(rd.start_lane) + int'(rd.num_lanes)) <= NUM_ELEM;

    assign space_available = CNT_W'(FIFO_DEPTH) - elem_available;

    assign wr.ready = wr.req_valid && (space_available >= CNT_W'(wr.num_lanes));
    assign rd.valid = rd.req_valid && (elem_available >= CNT_W'(rd.num_lanes));

    assign wr_fire = wr.valid && wr.ready;
    assign rd_fire = rd.valid && rd.ready;

    ////////////////////////////////////////////////////////////
    // lane alignment
    ////////////////////////////////////////////////////////////

    generate
        for (genvar i = 0; i < NUM_ELEM; i++) begin : g_lane
            assign wr_sel[i] = SEL_W'((i + int'(wr.start_lane)) % NUM_ELEM);
            // the inverse rotation puts the oldest element on lane start_lane
            assign rd_sel[i] = SEL_W'((i + NUM_ELEM - int'(rd.start_lane)) % NUM_ELEM);
            assign rd_raw[i] = mem[wrap_add(rd_ptr, i)];
            assign rd.data[i] = (i >= int'(rd.start_lane) &&
                                 i < int'(rd.start_lane) + int'(rd.num_lanes)) ? rd_x[i] : '0;
        end
    endgenerate

    xbar #(
        .ELEM_WIDTH   ( ELEM_WIDTH ),
        .NUM_ELEM     ( NUM_ELEM   )
    ) u_xbar_wr (
        .input_select ( wr_sel     ),
        .inputs       ( wr.data    ),
        .outputs      ( wr_x       )
    );

    xbar #(
        .ELEM_WIDTH   ( ELEM_WIDTH ),
        .NUM_ELEM     ( NUM_ELEM   )
    ) u_xbar_rd (
        .input_select ( rd_sel     ),
        .inputs       ( rd_raw     ),
        .outputs      ( rd_x       )
    );

    ////////////////////////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            elem_available <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wrap_add(wr_ptr, int'(wr.num_lanes));
            end
            if (rd_fire) begin
                rd_ptr <= wrap_add(rd_ptr, int'(rd.num_lanes));
            end
            elem_available <= elem_available
                            + (wr_fire ? CNT_W'(wr.num_lanes) : CNT_W'(0))
                            - (rd_fire ? CNT_W'(rd.num_lanes) : CNT_W'(0));
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            for (int i = 0; i < NUM_ELEM; i++) begin
                if (i < int'(wr.num_lanes)) begin
                    mem[wrap_add(wr_ptr, i)] <= wr_x[i];  // only the used lanes land
                end
            end
        end
    end

    // the count must survive a simultaneous write and read without overrun
    a_count_bound: assert property (@(posedge clk_i) disable iff (!arst_n)
        elem_available <= CNT_W'(FIFO_DEPTH));

    // a writer only ever offers a beat whose window fits the lanes
    a_no_bad_write: assert property (@(posedge clk_i) disable iff (!arst_n)
        wr.valid |-> wr.req_valid);

endmodule

//--- hw/xbar.sv
`timescale 1ns/1ps

module xbar #(
    parameter int ELEM_WIDTH = lane_pkg::LANE_ELEM_WIDTH,
    parameter int NUM_ELEM   = lane_pkg::LANE_NUM_ELEM
) (
    input  logic [NUM_ELEM-1:0][$clog2(NUM_ELEM)-1:0] input_select,
    input  logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0]       inputs,
    output logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0]       outputs
);

    // one NUM_ELEM:1 mux per output lane
    // several outputs may pick the same input, nothing here checks that
    generate
        for (genvar i = 0; i < NUM_ELEM; i++) begin : g_out
            assign outputs[i] = inputs[input_select[i]];
        end
    endgenerate

endmodule

//--- hw/lane_if.sv
`timescale 1ns/1ps

interface lane_if #(
    parameter int ELEM_WIDTH = lane_pkg::LANE_ELEM_WIDTH,
    parameter int NUM_ELEM   = lane_pkg::LANE_NUM_ELEM
);

    logic [$clog2(NUM_ELEM+1)-1:0]       num_lanes;   // lanes used in this beat
    logic [$clog2(NUM_ELEM)-1:0]         start_lane;  // first lane of the window
    logic [NUM_ELEM-1:0][ELEM_WIDTH-1:0] data;
    logic                                valid;
    logic                                ready;
    logic                                req_valid;   // start_lane + num_lanes fits the beat

    // push side, the source offers lanes together with their window
    modport src (output num_lanes, start_lane, data, valid, input ready, req_valid);
    modport dst (input num_lanes, start_lane, data, valid, output ready, req_valid);

    // pull side of a FIFO, the sink names the window and the source fills it
    // so the request fields travel toward the data source here
    modport src_pull (input num_lanes, start_lane, ready, output data, valid, req_valid);
    modport dst_pull (output num_lanes, start_lane, ready, input data, valid, req_valid);

endinterface

//--- hw/chan_pkg.sv
package chan_pkg;

    // number of independent channels behind the steer stage
    // must stay a power of two so that every channel number is legal
    localparam int CH_NUM_DEFAULT = 4;

    // bits needed to name one channel at the default count
    localparam int CH_ID_WIDTH_DEFAULT = $clog2(CH_NUM_DEFAULT);

endpackage

//--- hw/lane_pkg.sv
package lane_pkg;

    ////////////////////////////////////////////////////////////
    // lane geometry
    ////////////////////////////////////////////////////////////

    // every beat is NUM_ELEM lanes wide, each lane holds one element
    localparam int LANE_ELEM_WIDTH = 8;  // bits per lane element
    localparam int LANE_NUM_ELEM   = 4;  // lanes per beat

    ////////////////////////////////////////////////////////////
    // channel storage
    ////////////////////////////////////////////////////////////

    // elements one channel FIFO can hold
    // keep it at least NUM_ELEM so a full beat always fits an empty FIFO
    localparam int LANE_FIFO_DEPTH = 16;

endpackage
